// File: common/vrf_settings.svh
`ifndef VRF_SETTINGS_SVH
`define VRF_SETTINGS_SVH

// number of vector registers
`define VRF_DEPTH 32

// register word width in bits
`define VRF_WIDTH 32

// byte lanes per word
`define VRF_BYTES (`VRF_WIDTH/8)

// two bank groups, one per write port
`define VRF_W_PORTS 2

// ports 0 and 1 serve the ALU, port 2 is external
`define VRF_R_PORTS 3

`endif

// File: common/vrf_types_pkg.sv
`default_nettype none

`include "vrf_settings.svh"

package vrf_types_pkg;

   // register index
   typedef logic [$clog2(`VRF_DEPTH)-1:0] vreg_addr_t;

   // one register word
   typedef logic [`VRF_WIDTH-1:0] vreg_data_t;

   // one enable per byte lane
   typedef logic [`VRF_BYTES-1:0] vreg_bwe_t;

endpackage

`default_nettype wire

// File: common/valu_pkg.sv
`default_nettype none

package valu_pkg;

   // full-word operations, add and sub wrap around
   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_XOR = 2'd2,
      OP_AND = 2'd3
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_FETCH = 2'd1,
      ST_EXEC  = 2'd2,
      ST_WB    = 2'd3
   } alu_state_e;

endpackage

`default_nettype wire

// File: vrf/sdp_bwe_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "vrf_settings.svh"

module sdp_bwe_ram
   import vrf_types_pkg::*;
#(
   parameter int DEPTH    = `VRF_DEPTH,
   parameter int NB_BYTES = `VRF_BYTES
)
(
   input  wire logic       clk,
   input  wire vreg_addr_t wr_addr_i,
   input  wire vreg_bwe_t  wr_bwe_i,
   input  wire vreg_data_t wr_data_i,
   input  wire logic       rd_en_i,
   input  wire vreg_addr_t rd_addr_i,
   output vreg_data_t      rd_data_o
);

   logic [NB_BYTES-1:0][7:0] mem [DEPTH];

   // every copy of a group has to start equal for the XOR decode
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = '0;
   end

   always_ff @(posedge clk)
   begin
      for (int b = 0; b < NB_BYTES; b++)
      begin
         if (wr_bwe_i[b])
            mem[wr_addr_i][b] <= wr_data_i[b*8 +: 8];
      end
      // read-first, output held between enabled reads
      if (rd_en_i)
         rd_data_o <= mem[rd_addr_i];
   end

endmodule

`default_nettype wire

// File: vrf/vrf_xor.sv
`timescale 1ns/1ps
`default_nettype none

`include "vrf_settings.svh"

module vrf_xor
   import vrf_types_pkg::*;
(
   input  wire logic                            clk,
   input  wire logic                            rstn,
   // write ports
   input  wire vreg_addr_t [`VRF_W_PORTS-1:0]   waddr_i,
   input  wire vreg_bwe_t  [`VRF_W_PORTS-1:0]   bwe_i,
   input  wire vreg_data_t [`VRF_W_PORTS-1:0]   din_i,
   // read ports
   input  wire vreg_addr_t [`VRF_R_PORTS-1:0]   raddr_i,
   input  wire logic       [`VRF_R_PORTS-1:0]   ren_i,
   output vreg_data_t      [`VRF_R_PORTS-1:0]   dout_o
);

   localparam int NG = `VRF_W_PORTS;
   localparam int NR = `VRF_R_PORTS;
   localparam int NB = `VRF_BYTES;

   // write port input registers
   vreg_addr_t waddr_q [NG];
   vreg_bwe_t  bwe_q   [NG];
   vreg_data_t din_q   [NG];

   // lvt_dout[g] is group g's content at the other port's address
   vreg_data_t lvt_dout  [NG];
   vreg_data_t code_word [NG];
   vreg_data_t bank_dout [NG][NR];

   // bytes the other group overwrote at our address while we read its LVT
   vreg_bwe_t  hit_q [NG];
   vreg_data_t fix_q [NG];

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         for (int g = 0; g < NG; g++)
         begin
            waddr_q[g] <= '0;
            bwe_q[g]   <= '0;
            din_q[g]   <= '0;
            hit_q[g]   <= '0;
         end
      end
      else
      begin
         for (int g = 0; g < NG; g++)
         begin
            waddr_q[g] <= waddr_i[g];
            bwe_q[g]   <= bwe_i[g];
            din_q[g]   <= din_i[g];
            hit_q[g]   <= (waddr_q[1 - g] == waddr_i[g]) ? bwe_q[1 - g] : '0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int g = 0; g < NG; g++)
         fix_q[g] <= code_word[1 - g];
   end

   // code each word against the other group's current content
   always_comb
   begin
      vreg_data_t other_word;
      for (int g = 0; g < NG; g++)
      begin
         other_word = lvt_dout[1 - g];
         for (int b = 0; b < NB; b++)
         begin
            if (hit_q[g][b])
               other_word[b*8 +: 8] = fix_q[g][b*8 +: 8];
         end
         code_word[g] = din_q[g] ^ other_word;
      end
   end

   for (genvar g = 0; g < NG; g++)
   begin : gen_group
      sdp_bwe_ram #(
         .DEPTH    (`VRF_DEPTH),
         .NB_BYTES (NB)
      ) u_lvt_ram (
         .clk       (clk),
         .wr_addr_i (waddr_q[g]),
         .wr_bwe_i  (bwe_q[g]),
         .wr_data_i (code_word[g]),
         .rd_en_i   (1'b1),
         .rd_addr_i (waddr_i[1 - g]),
         .rd_data_o (lvt_dout[g])
      );

      // one bank per read port, same content as the LVT copy
      for (genvar r = 0; r < NR; r++)
      begin : gen_bank
         sdp_bwe_ram #(
            .DEPTH    (`VRF_DEPTH),
            .NB_BYTES (NB)
         ) u_bank_ram (
            .clk       (clk),
            .wr_addr_i (waddr_q[g]),
            .wr_bwe_i  (bwe_q[g]),
            .wr_data_i (code_word[g]),
            .rd_en_i   (ren_i[r]),
            .rd_addr_i (raddr_i[r]),
            .rd_data_o (bank_dout[g][r])
         );
      end
   end

   // xor of all groups gives back the last written word
   always_comb
   begin
      for (int r = 0; r < NR; r++)
      begin
         dout_o[r] = '0;
         for (int g = 0; g < NG; g++)
            dout_o[r] = dout_o[r] ^ bank_dout[g][r];
      end
   end

endmodule

`default_nettype wire

// File: logic/write_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "vrf_settings.svh"

module write_arbiter
   import vrf_types_pkg::*;
(
   // ALU writeback
   input  wire logic                        wb_en_i,
   input  wire vreg_addr_t                  wb_addr_i,
   input  wire vreg_data_t                  wb_data_i,
   // external load
   input  wire logic                        ld_en_i,
   input  wire vreg_addr_t                  ld_addr_i,
   input  wire vreg_bwe_t                   ld_bwe_i,
   input  wire vreg_data_t                  ld_data_i,
   // register file write ports
   output vreg_addr_t [`VRF_W_PORTS-1:0]    waddr_o,
   output vreg_bwe_t  [`VRF_W_PORTS-1:0]    bwe_o,
   output vreg_data_t [`VRF_W_PORTS-1:0]    din_o,
   output logic                             ld_conflict_o
);

   logic collide;

   // same address on both ports is undefined in the XOR code
   assign collide = wb_en_i && ld_en_i && (wb_addr_i == ld_addr_i);

   always_comb
   begin
      // port 0 carries the ALU, full word
      waddr_o[0] = wb_addr_i;
      bwe_o[0]   = {$bits(vreg_bwe_t){wb_en_i}};
      din_o[0]   = wb_data_i;
      // port 1 carries loads, ALU wins a collision
      waddr_o[1] = ld_addr_i;
      bwe_o[1]   = (ld_en_i && !collide) ? ld_bwe_i : '0;
      din_o[1]   = ld_data_i;
   end

   assign ld_conflict_o = collide;

endmodule

`default_nettype wire

// File: logic/vec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module vec_alu
   import vrf_types_pkg::*;
   import valu_pkg::*;
(
   input  wire logic             clk,
   input  wire logic             rstn,
   // command
   input  wire logic             op_en_i,
   input  wire alu_op_e          op_code_i,
   input  wire vreg_addr_t       op_rd_i,
   input  wire vreg_addr_t       op_rs1_i,
   input  wire vreg_addr_t       op_rs2_i,
   // operand reads on register file ports 0 and 1
   output vreg_addr_t [1:0]      rs_addr_o,
   output logic       [1:0]      rs_en_o,
   input  wire vreg_data_t [1:0] rs_data_i,
   // writeback
   output logic                  wb_en_o,
   output vreg_addr_t            wb_addr_o,
   output vreg_data_t            wb_data_o,
   output logic                  busy_o
);

   alu_state_e state_q;
   alu_state_e state_d;

   // latched command
   alu_op_e    op_q;
   vreg_addr_t rd_q;
   vreg_addr_t rs1_q;
   vreg_addr_t rs2_q;

   vreg_data_t alu_res;
   vreg_data_t res_q;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:
         begin
            if (op_en_i)
               state_d = ST_FETCH;
         end
         ST_FETCH: state_d = ST_EXEC;
         ST_EXEC:  state_d = ST_WB;
         default:  state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
         state_q <= ST_IDLE;
      else
         state_q <= state_d;
   end

   always_ff @(posedge clk)
   begin
      if (state_q == ST_IDLE && op_en_i)
      begin
         op_q  <= op_code_i;
         rd_q  <= op_rd_i;
         rs1_q <= op_rs1_i;
         rs2_q <= op_rs2_i;
      end
      if (state_q == ST_EXEC)
         res_q <= alu_res;
   end

   // operands arrive from the read registers during ST_EXEC
   always_comb
   begin
      case (op_q)
         OP_ADD:  alu_res = rs_data_i[0] + rs_data_i[1];
         OP_SUB:  alu_res = rs_data_i[0] - rs_data_i[1];
         OP_XOR:  alu_res = rs_data_i[0] ^ rs_data_i[1];
         default: alu_res = rs_data_i[0] & rs_data_i[1];
      endcase
   end

   assign rs_addr_o[0] = rs1_q;
   assign rs_addr_o[1] = rs2_q;
   assign rs_en_o      = {2{state_q == ST_FETCH}};

   assign wb_en_o   = (state_q == ST_WB);
   assign wb_addr_o = rd_q;
   assign wb_data_o = res_q;
   assign busy_o    = (state_q != ST_IDLE);

endmodule

`default_nettype wire

// File: logic/vec_regfile_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vrf_settings.svh"

module vec_regfile_top
   import vrf_types_pkg::*;
   import valu_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rstn,
   // load path
   input  wire logic       ld_en_i,
   input  wire vreg_addr_t ld_addr_i,
   input  wire vreg_bwe_t  ld_bwe_i,
   input  wire vreg_data_t ld_data_i,
   // ALU command
   input  wire logic       op_en_i,
   input  wire alu_op_e    op_code_i,
   input  wire vreg_addr_t op_rd_i,
   input  wire vreg_addr_t op_rs1_i,
   input  wire vreg_addr_t op_rs2_i,
   // external read
   input  wire logic       rd_en_i,
   input  wire vreg_addr_t rd_addr_i,
   output vreg_data_t      rd_data_o,
   output logic            busy_o,
   output logic            ld_conflict_o
);

   vreg_addr_t [1:0]                rs_addr;
   logic       [1:0]                rs_en;

   logic                            wb_en;
   vreg_addr_t                      wb_addr;
   vreg_data_t                      wb_data;

   vreg_addr_t [`VRF_W_PORTS-1:0]   waddr;
   vreg_bwe_t  [`VRF_W_PORTS-1:0]   bwe;
   vreg_data_t [`VRF_W_PORTS-1:0]   din;
   vreg_data_t [`VRF_R_PORTS-1:0]   dout;

   vec_alu u_vec_alu (
      .clk       (clk),
      .rstn      (rstn),
      .op_en_i   (op_en_i),
      .op_code_i (op_code_i),
      .op_rd_i   (op_rd_i),
      .op_rs1_i  (op_rs1_i),
      .op_rs2_i  (op_rs2_i),
      .rs_addr_o (rs_addr),
      .rs_en_o   (rs_en),
      .rs_data_i (dout[1:0]),
      .wb_en_o   (wb_en),
      .wb_addr_o (wb_addr),
      .wb_data_o (wb_data),
      .busy_o    (busy_o)
   );

   write_arbiter u_write_arbiter (
      .wb_en_i       (wb_en),
      .wb_addr_i     (wb_addr),
      .wb_data_i     (wb_data),
      .ld_en_i       (ld_en_i),
      .ld_addr_i     (ld_addr_i),
      .ld_bwe_i      (ld_bwe_i),
      .ld_data_i     (ld_data_i),
      .waddr_o       (waddr),
      .bwe_o         (bwe),
      .din_o         (din),
      .ld_conflict_o (ld_conflict_o)
   );

   // read port 2 is the external one
   vrf_xor u_vrf_xor (
      .clk     (clk),
      .rstn    (rstn),
      .waddr_i (waddr),
      .bwe_i   (bwe),
      .din_i   (din),
      .raddr_i ({rd_addr_i, rs_addr}),
      .ren_i   ({rd_en_i, rs_en}),
      .dout_o  (dout)
   );

   assign rd_data_o = dout[`VRF_R_PORTS-1];

endmodule

`default_nettype wire

// File: testbench/vrf_sva.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_sva
   import vrf_types_pkg::*;
(
   input wire logic             clk,
   input wire logic             rstn,
   input wire vreg_addr_t [1:0] waddr,
   input wire vreg_bwe_t  [1:0] bwe,
   input wire logic             op_en,
   input wire logic             wb_en,
   input wire logic             busy
);

   int unsigned sva_errs = 0;

   // XOR code cannot store two writes to one address
   a_one_addr: assert property (@(posedge clk) disable iff (!rstn)
      !((|bwe[0]) && (|bwe[1]) && (waddr[0] == waddr[1])))
   else
   begin
      $error("both write ports enabled on one address");
      sva_errs++;
   end

   a_wb_pulse: assert property (@(posedge clk) disable iff (!rstn)
      wb_en |=> !wb_en)
   else
   begin
      $error("writeback enable longer than one cycle");
      sva_errs++;
   end

   // fetch, exec, writeback
   a_busy_len: assert property (@(posedge clk) disable iff (!rstn)
      (op_en && !busy) |=> busy [*3] ##1 !busy)
   else
   begin
      $error("busy not high for exactly three cycles after accept");
      sva_errs++;
   end

   a_reset_idle: assert property (@(posedge clk)
      $rose(rstn) |-> (!busy && !wb_en))
   else
   begin
      $error("outputs active after reset");
      sva_errs++;
   end

endmodule

bind vrf_xor vrf_sva u_vrf_sva (
   .clk   (clk),
   .rstn  (rstn),
   .waddr (waddr_i),
   .bwe   (bwe_i),
   .op_en (1'b0),
   .wb_en (1'b0),
   .busy  (1'b0)
);

bind vec_alu vrf_sva u_vrf_sva (
   .clk   (clk),
   .rstn  (rstn),
   .waddr ('0),
   .bwe   ('0),
   .op_en (op_en_i),
   .wb_en (wb_en_o),
   .busy  (busy_o)
);

`default_nettype wire

// File: testbench/tb_vec_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "vrf_settings.svh"

module tb_vec_regfile
   import vrf_types_pkg::*;
   import valu_pkg::*;
();

   localparam int WAIT_LIMIT = 16;

   logic       clk;
   logic       rstn;
   logic       ld_en;
   vreg_addr_t ld_addr;
   vreg_bwe_t  ld_bwe;
   vreg_data_t ld_data;
   logic       op_en;
   alu_op_e    op_code;
   vreg_addr_t op_rd;
   vreg_addr_t op_rs1;
   vreg_addr_t op_rs2;
   logic       rd_en;
   vreg_addr_t rd_addr;
   vreg_data_t rd_data;
   logic       busy;
   logic       ld_conflict;

   // what every register should hold
   vreg_data_t  shadow [`VRF_DEPTH];
   int unsigned lcg_state = 51507;
   int          value_errs = 0;
   int          timeout_errs = 0;

   // expected read result registered alongside rd_en
   vreg_data_t rd_exp;
   string      rd_name;
   logic       rd_due;
   vreg_data_t rd_exp_q;
   string      rd_name_q;
   logic       conflict_seen;

   vec_regfile_top UUT (
      .clk           (clk),
      .rstn          (rstn),
      .ld_en_i       (ld_en),
      .ld_addr_i     (ld_addr),
      .ld_bwe_i      (ld_bwe),
      .ld_data_i     (ld_data),
      .op_en_i       (op_en),
      .op_code_i     (op_code),
      .op_rd_i       (op_rd),
      .op_rs1_i      (op_rs1),
      .op_rs2_i      (op_rs2),
      .rd_en_i       (rd_en),
      .rd_addr_i     (rd_addr),
      .rd_data_o     (rd_data),
      .busy_o        (busy),
      .ld_conflict_o (ld_conflict)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic vreg_data_t alu_ref(input alu_op_e op, input vreg_data_t x,
                                          input vreg_data_t y);
      case (op)
         OP_ADD:  return x + y;
         OP_SUB:  return x - y;
         OP_XOR:  return x ^ y;
         default: return x & y;
      endcase
   endfunction

   function automatic vreg_data_t merge_bytes(input vreg_data_t old_word,
                                              input vreg_data_t new_word,
                                              input vreg_bwe_t bwe);
      vreg_data_t res;
      res = old_word;
      for (int k = 0; k < $bits(vreg_bwe_t); k++)
      begin
         if (bwe[k])
            res[k*8 +: 8] = new_word[k*8 +: 8];
      end
      return res;
   endfunction

   task automatic check_value(input string name, input vreg_data_t exp, input vreg_data_t act);
      if (act !== exp)
      begin
         value_errs++;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic finish_run();
      int sva_errs;
      sva_errs = UUT.u_vrf_xor.u_vrf_sva.sva_errs + UUT.u_vec_alu.u_vrf_sva.sva_errs;
      $display("errors: value %0d, timeout %0d, assertion %0d",
               value_errs, timeout_errs, sva_errs);
      if (value_errs == 0 && timeout_errs == 0 && sva_errs == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   endtask

   task automatic fail_timeout(input string what);
      timeout_errs++;
      $display("timeout: gave up waiting for %s", what);
      finish_run();
   endtask

   task automatic load_word(input vreg_addr_t addr, input vreg_bwe_t bwe,
                            input vreg_data_t data);
      ld_en   = 1'b1;
      ld_addr = addr;
      ld_bwe  = bwe;
      ld_data = data;
      shadow[addr] = merge_bytes(shadow[addr], data, bwe);
      @(negedge clk);
      ld_en  = 1'b0;
      ld_bwe = '0;
      // write lands two edges after the strobe
      @(negedge clk);
   endtask

   task automatic read_check(input string name, input vreg_addr_t addr);
      rd_en   = 1'b1;
      rd_addr = addr;
      rd_exp  = shadow[addr];
      rd_name = name;
      @(negedge clk);
      rd_en = 1'b0;
   endtask

   task automatic issue_op(input alu_op_e op, input vreg_addr_t rd, input vreg_addr_t rs1,
                           input vreg_addr_t rs2);
      op_en   = 1'b1;
      op_code = op;
      op_rd   = rd;
      op_rs1  = rs1;
      op_rs2  = rs2;
      shadow[rd] = alu_ref(op, shadow[rs1], shadow[rs2]);
      @(negedge clk);
      op_en = 1'b0;
   endtask

   task automatic wait_result();
      int cnt;
      cnt = 0;
      while (busy && cnt < WAIT_LIMIT)
      begin
         @(negedge clk);
         cnt++;
      end
      // result readable one cycle after idle
      if (busy)
         fail_timeout("busy_o to fall");
      else
         @(negedge clk);
   endtask

   // third busy cycle is the writeback cycle
   task automatic wait_writeback();
      int seen;
      int cnt;
      seen = 0;
      cnt  = 0;
      while (seen < 3 && cnt < WAIT_LIMIT)
      begin
         if (busy)
            seen++;
         if (seen < 3)
         begin
            @(negedge clk);
            cnt++;
         end
      end
      if (seen < 3)
         fail_timeout("the ALU writeback cycle");
   endtask

   always @(posedge clk)
   begin
      rd_due        <= rd_en && rstn;
      rd_exp_q      <= rd_exp;
      rd_name_q     <= rd_name;
      conflict_seen <= ld_conflict;
   end

   // read data is stable from the edge after rd_en
   always @(negedge clk)
   begin
      if (rd_due)
         check_value(rd_name_q, rd_exp_q, rd_data);
   end

   initial
   begin
      vreg_addr_t a;
      vreg_addr_t b;
      vreg_addr_t r;
      vreg_addr_t la;
      vreg_bwe_t  m;
      vreg_data_t d;
      rstn    = 1'b0;
      ld_en   = 1'b0;
      ld_addr = '0;
      ld_bwe  = '0;
      ld_data = '0;
      op_en   = 1'b0;
      op_code = OP_ADD;
      op_rd   = '0;
      op_rs1  = '0;
      op_rs2  = '0;
      rd_en   = 1'b0;
      rd_addr = '0;
      rd_exp  = '0;
      rd_name = "";
      for (int i = 0; i < 2; i++)
         @(negedge clk);
      rstn = 1'b1;
      // strobe without byte enables so a stuck writeback shows as a conflict
      ld_en = 1'b1;
      @(negedge clk);
      check_value("reset_busy", '0, busy);
      check_value("reset_conflict", '0, ld_conflict);
      ld_en = 1'b0;

      // full words everywhere then read all back
      for (int i = 0; i < `VRF_DEPTH; i++)
         load_word(vreg_addr_t'(i), '1, lcg_next());
      for (int i = 0; i < `VRF_DEPTH; i++)
         read_check($sformatf("full_load_%0d", i), vreg_addr_t'(i));

      for (int i = 0; i < 16; i++)
      begin
         a = vreg_addr_t'(lcg_next() >> 27);
         m = vreg_bwe_t'(lcg_next() >> 28);
         if (m == '0)
            m = 4'b0101;
         load_word(a, m, lcg_next());
         read_check($sformatf("byte_load_%0d", i), a);
      end

      // every op with some rd equal to rs1
      for (int i = 0; i < 24; i++)
      begin
         a = vreg_addr_t'(lcg_next() >> 27);
         b = vreg_addr_t'(lcg_next() >> 27);
         r = (i % 3 == 0) ? a : vreg_addr_t'(lcg_next() >> 27);
         issue_op(alu_op_e'(i % 4), r, a, b);
         wait_result();
         read_check($sformatf("alu_%0d", i), r);
      end

      // load to another address beside the writeback
      a  = vreg_addr_t'(lcg_next() >> 27);
      b  = vreg_addr_t'(lcg_next() >> 27);
      r  = vreg_addr_t'(lcg_next() >> 27);
      la = r + 1'b1;
      d  = lcg_next();
      issue_op(OP_ADD, r, a, b);
      wait_writeback();
      ld_en   = 1'b1;
      ld_addr = la;
      ld_bwe  = '1;
      ld_data = d;
      shadow[la] = d;
      @(negedge clk);
      ld_en  = 1'b0;
      ld_bwe = '0;
      check_value("wb_load_conflict", '0, conflict_seen);
      wait_result();
      read_check("wb_load_alu", r);
      read_check("wb_load_other", la);

      // same address where the ALU result must win
      issue_op(OP_SUB, r, a, b);
      wait_writeback();
      ld_en   = 1'b1;
      ld_addr = r;
      ld_bwe  = '1;
      ld_data = ~shadow[r];
      @(negedge clk);
      ld_en  = 1'b0;
      ld_bwe = '0;
      check_value("wb_same_conflict", 1, conflict_seen);
      wait_result();
      read_check("wb_same_alu", r);

      // second command arrives while busy
      issue_op(OP_XOR, r, a, b);
      op_en   = 1'b1;
      op_code = OP_ADD;
      op_rd   = la;
      op_rs1  = a;
      op_rs2  = b;
      @(negedge clk);
      op_en = 1'b0;
      wait_result();
      read_check("busy_dropped", la);
      read_check("busy_first", r);

      for (int i = 0; i < 2; i++)
         @(negedge clk);
      finish_run();
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/vrf_types_pkg.sv
common/valu_pkg.sv
vrf/sdp_bwe_ram.sv
vrf/vrf_xor.sv
logic/write_arbiter.sv
logic/vec_alu.sv
logic/vec_regfile_top.sv
testbench/vrf_sva.sv
testbench/tb_vec_regfile.sv

// File: Bender.yml
package:
  name: vec_regfile

export_include_dirs:
  - common

sources:
  - files:
      - common/vrf_types_pkg.sv
      - common/valu_pkg.sv
      - vrf/sdp_bwe_ram.sv
      - vrf/vrf_xor.sv
      - logic/write_arbiter.sv
      - logic/vec_alu.sv
      - logic/vec_regfile_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/vrf_sva.sv
      - testbench/tb_vec_regfile.sv
